/* src/acc_cfg_pkg.sv */
`default_nettype none

package acc_cfg_pkg;

  // Operand and result width
  localparam int XLEN = 32;

  // Transaction IDs and scoreboard size
  localparam int TRANS_ID_BITS = 3;
  localparam int NR_SB_ENTRIES = 8;

  // Dispatcher queue, issue stops at depth minus one
  localparam int INSN_QUEUE_DEPTH = 3;
  localparam int INSN_PTR_BITS    = $clog2(INSN_QUEUE_DEPTH);
  localparam int INSN_CNT_BITS    = $clog2(INSN_QUEUE_DEPTH + 1);

  // Request buffer, one credit per entry
  localparam int REQ_BUF_DEPTH = 4;
  localparam int BUF_PTR_BITS  = $clog2(REQ_BUF_DEPTH);
  localparam int BUF_CNT_BITS  = $clog2(REQ_BUF_DEPTH + 1);
  localparam int CREDIT_BITS   = 3;

endpackage

`default_nettype wire

/* src/acc_isa_pkg.sv */
`default_nettype none

package acc_isa_pkg;

  // Major opcodes, custom-0 and custom-1 slots
  localparam logic [6:0] OPC_ACC_R = 7'b0001011;
  localparam logic [6:0] OPC_ACC_I = 7'b0101011;

  // funct3 codes
  localparam logic [2:0] FN_ADD = 3'b000;
  // Explicit subtract, only legal in the register form
  localparam logic [2:0] FN_SUB = 3'b001;
  localparam logic [2:0] FN_XOR = 3'b100;
  localparam logic [2:0] FN_AND = 3'b111;

  // Turns FN_ADD into a subtract in the register form
  localparam logic [6:0] FN7_ALT = 7'b0100000;

  // Register-register form
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } acc_insn_r_t;

  // Register-immediate form
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } acc_insn_i_t;

  // Same word seen either way, opcode and funct3 share their bits
  typedef union packed {
    acc_insn_r_t r;
    acc_insn_i_t i;
  } acc_insn_u;

endpackage

`default_nettype wire

/* src/acc_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module acc_dispatcher (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  flush_i,
  // Issue stage
  input  logic                                  issue_valid_i,
  input  logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] issue_trans_id_i,
  input  logic [31:0]                           issue_insn_i,
  input  logic [acc_cfg_pkg::XLEN-1:0]          issue_rs1_i,
  input  logic [acc_cfg_pkg::XLEN-1:0]          issue_rs2_i,
  output logic                                  issue_ready_o,
  // Commit stage
  input  logic                                  commit_i,
  input  logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] commit_trans_id_i,
  // Credit link towards the request buffer
  output logic                                  req_push_o,
  output logic [31:0]                           req_insn_o,
  output logic [acc_cfg_pkg::XLEN-1:0]          req_rs1_o,
  output logic [acc_cfg_pkg::XLEN-1:0]          req_rs2_o,
  output logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] req_trans_id_o,
  input  logic                                  credit_ret_i
);

  import acc_cfg_pkg::*;

  // Queue storage
  logic [31:0]              q_insn [INSN_QUEUE_DEPTH];
  logic [XLEN-1:0]          q_rs1  [INSN_QUEUE_DEPTH];
  logic [XLEN-1:0]          q_rs2  [INSN_QUEUE_DEPTH];
  logic [TRANS_ID_BITS-1:0] q_id   [INSN_QUEUE_DEPTH];

  logic [INSN_PTR_BITS-1:0] wr_ptr_q, rd_ptr_q;
  logic [INSN_CNT_BITS-1:0] count_q, count_d;
  logic                     q_empty, q_push, q_pop;
  logic                     issue_ready_q;

  // Head of the queue, or the incoming entry when empty
  logic                     head_valid;
  logic [TRANS_ID_BITS-1:0] head_id;

  // Speculation tracking, indexed by transaction ID
  logic [NR_SB_ENTRIES-1:0] pending_q, pending_d;
  logic [NR_SB_ENTRIES-1:0] ready_q, ready_d;
  logic [NR_SB_ENTRIES-1:0] commit_ready;

  logic [CREDIT_BITS-1:0]   credit_q, credit_d;
  logic                     send;

  assign q_empty = (count_q == '0);
  // Flush drops anything issued in the same cycle
  assign q_push  = issue_valid_i && !flush_i;

  // Fall-through head
  assign head_valid     = !q_empty || issue_valid_i;
  assign head_id        = q_empty ? issue_trans_id_i : q_id[rd_ptr_q];
  assign req_insn_o     = q_empty ? issue_insn_i : q_insn[rd_ptr_q];
  assign req_rs1_o      = q_empty ? issue_rs1_i : q_rs1[rd_ptr_q];
  assign req_rs2_o      = q_empty ? issue_rs2_i : q_rs2[rd_ptr_q];
  assign req_trans_id_o = head_id;

  // Send only committed work, and only with a free buffer entry
  assign send       = head_valid && commit_ready[head_id] && (credit_q != '0) && !flush_i;
  assign q_pop      = send;
  assign req_push_o = send;

  assign issue_ready_o = issue_ready_q;

  always_comb begin
    count_d = count_q;
    if (flush_i) begin
      count_d = '0;
    end else begin
      case ({q_push, q_pop})
        2'b10:   count_d = count_q + 1'b1;
        2'b01:   count_d = count_q - 1'b1;
        default: count_d = count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (q_push) begin
        wr_ptr_q <= (wr_ptr_q == INSN_PTR_BITS'(INSN_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (q_pop) begin
        rd_ptr_q <= (rd_ptr_q == INSN_PTR_BITS'(INSN_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Ready is registered, so it stays low while reset is held
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q       <= '0;
      issue_ready_q <= 1'b0;
    end else begin
      count_q       <= count_d;
      issue_ready_q <= (count_d < INSN_CNT_BITS'(INSN_QUEUE_DEPTH - 1));
    end
  end

  always_ff @(posedge clk_i) begin
    if (q_push) begin
      q_insn[wr_ptr_q] <= issue_insn_i;
      q_rs1[wr_ptr_q]  <= issue_rs1_i;
      q_rs2[wr_ptr_q]  <= issue_rs2_i;
      q_id[wr_ptr_q]   <= issue_trans_id_i;
    end
  end

  // Commit turns a pending ID into a ready one
  always_comb begin
    pending_d    = pending_q;
    commit_ready = ready_q;
    if (q_push) begin
      pending_d[issue_trans_id_i] = 1'b1;
    end
    if (flush_i) begin
      pending_d = '0;
    end
    // Commits for unknown IDs fall through untouched
    if (commit_i && pending_q[commit_trans_id_i]) begin
      commit_ready[commit_trans_id_i] = 1'b1;
      pending_d[commit_trans_id_i]    = 1'b0;
    end
  end

  // Sending consumes the ready mark
  always_comb begin
    ready_d = commit_ready;
    if (send) begin
      ready_d[head_id] = 1'b0;
    end
  end

  // Credits: minus one per send, plus one per release
  always_comb begin
    credit_d = credit_q;
    if (send && !credit_ret_i) begin
      credit_d = credit_q - 1'b1;
    end else if (credit_ret_i && !send) begin
      credit_d = credit_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      ready_q   <= '0;
      credit_q  <= CREDIT_BITS'(REQ_BUF_DEPTH);
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
      credit_q  <= credit_d;
    end
  end

endmodule

`default_nettype wire

/* src/acc_req_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module acc_req_buffer (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Write side, guarded by the dispatcher's credits
  input  logic                                  push_i,
  input  logic [31:0]                           insn_i,
  input  logic [acc_cfg_pkg::XLEN-1:0]          rs1_i,
  input  logic [acc_cfg_pkg::XLEN-1:0]          rs2_i,
  input  logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] trans_id_i,
  // Read side
  input  logic                                  pop_i,
  output logic                                  valid_o,
  output logic [31:0]                           insn_o,
  output logic [acc_cfg_pkg::XLEN-1:0]          rs1_o,
  output logic [acc_cfg_pkg::XLEN-1:0]          rs2_o,
  output logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] trans_id_o,
  output logic                                  credit_ret_o
);

  import acc_cfg_pkg::*;

  logic [31:0]              mem_insn [REQ_BUF_DEPTH];
  logic [XLEN-1:0]          mem_rs1  [REQ_BUF_DEPTH];
  logic [XLEN-1:0]          mem_rs2  [REQ_BUF_DEPTH];
  logic [TRANS_ID_BITS-1:0] mem_id   [REQ_BUF_DEPTH];

  logic [BUF_PTR_BITS-1:0]  wr_ptr_q, rd_ptr_q;
  logic [BUF_CNT_BITS-1:0]  count_q;
  logic                     pop_ok;

  // Head comes from storage only, so a push shows up a cycle later
  assign valid_o    = (count_q != '0);
  assign insn_o     = mem_insn[rd_ptr_q];
  assign rs1_o      = mem_rs1[rd_ptr_q];
  assign rs2_o      = mem_rs2[rd_ptr_q];
  assign trans_id_o = mem_id[rd_ptr_q];

  // Each released entry hands one credit back
  assign pop_ok       = pop_i && valid_o;
  assign credit_ret_o = pop_ok;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == BUF_PTR_BITS'(REQ_BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == BUF_PTR_BITS'(REQ_BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_insn[wr_ptr_q] <= insn_i;
      mem_rs1[wr_ptr_q]  <= rs1_i;
      mem_rs2[wr_ptr_q]  <= rs2_i;
      mem_id[wr_ptr_q]   <= trans_id_i;
    end
  end

endmodule

`default_nettype wire

/* src/acc_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module acc_alu (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Request buffer head
  input  logic                                  buf_valid_i,
  input  acc_isa_pkg::acc_insn_u                insn_i,
  input  logic [acc_cfg_pkg::XLEN-1:0]          rs1_i,
  input  logic [acc_cfg_pkg::XLEN-1:0]          rs2_i,
  input  logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] trans_id_i,
  output logic                                  buf_pop_o,
  // Response towards the core
  input  logic                                  resp_ready_i,
  output logic                                  resp_valid_o,
  output logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] resp_trans_id_o,
  output logic [acc_cfg_pkg::XLEN-1:0]          resp_result_o,
  output logic                                  resp_error_o
);

  import acc_cfg_pkg::*;
  import acc_isa_pkg::*;

  logic [XLEN-1:0]          imm_ext;
  logic [XLEN-1:0]          alu_res;
  logic                     alu_err;

  logic                     resp_valid_q;
  logic [TRANS_ID_BITS-1:0] resp_id_q;
  logic [XLEN-1:0]          resp_res_q;
  logic                     resp_err_q;

  assign imm_ext = {{(XLEN - 12){insn_i.i.imm12[11]}}, insn_i.i.imm12};

  // Take a new request when the output slot is free or draining
  assign buf_pop_o = buf_valid_i && (!resp_valid_q || resp_ready_i);

  always_comb begin
    // Errors leave a zero result
    alu_res = '0;
    alu_err = 1'b0;
    case (insn_i.r.opcode)
      OPC_ACC_R: begin
        case (insn_i.r.funct3)
          FN_ADD: alu_res = (insn_i.r.funct7 == FN7_ALT) ? rs1_i - rs2_i : rs1_i + rs2_i;
          FN_SUB: alu_res = rs1_i - rs2_i;
          FN_XOR: alu_res = rs1_i ^ rs2_i;
          FN_AND: alu_res = rs1_i & rs2_i;
          default: alu_err = 1'b1;
        endcase
      end
      OPC_ACC_I: begin
        case (insn_i.i.funct3)
          FN_ADD: alu_res = rs1_i + imm_ext;
          FN_XOR: alu_res = rs1_i ^ imm_ext;
          FN_AND: alu_res = rs1_i & imm_ext;
          // No subtract with an immediate, FN_SUB lands here too
          default: alu_err = 1'b1;
        endcase
      end
      default: alu_err = 1'b1;
    endcase
  end

  // One-entry output slot
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else if (buf_pop_o) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Fields only change on a pop, so they hold under back-pressure
  always_ff @(posedge clk_i) begin
    if (buf_pop_o) begin
      resp_id_q  <= trans_id_i;
      resp_res_q <= alu_res;
      resp_err_q <= alu_err;
    end
  end

  assign resp_valid_o    = resp_valid_q;
  assign resp_trans_id_o = resp_id_q;
  assign resp_result_o   = resp_res_q;
  assign resp_error_o    = resp_err_q;

endmodule

`default_nettype wire

/* src/acc_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module acc_subsys_top (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  flush_i,
  // Issue stage
  input  logic                                  issue_valid_i,
  input  logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] issue_trans_id_i,
  input  logic [31:0]                           issue_insn_i,
  input  logic [acc_cfg_pkg::XLEN-1:0]          issue_rs1_i,
  input  logic [acc_cfg_pkg::XLEN-1:0]          issue_rs2_i,
  output logic                                  issue_ready_o,
  // Commit stage
  input  logic                                  commit_i,
  input  logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] commit_trans_id_i,
  // Responses
  input  logic                                  resp_ready_i,
  output logic                                  resp_valid_o,
  output logic [acc_cfg_pkg::TRANS_ID_BITS-1:0] resp_trans_id_o,
  output logic [acc_cfg_pkg::XLEN-1:0]          resp_result_o,
  output logic                                  resp_error_o
);

  import acc_cfg_pkg::*;

  // Dispatcher to buffer
  logic                     req_push;
  logic [31:0]              req_insn;
  logic [XLEN-1:0]          req_rs1, req_rs2;
  logic [TRANS_ID_BITS-1:0] req_trans_id;
  logic                     credit_ret;

  // Buffer to accelerator
  logic                     buf_valid, buf_pop;
  logic [31:0]              buf_insn;
  logic [XLEN-1:0]          buf_rs1, buf_rs2;
  logic [TRANS_ID_BITS-1:0] buf_trans_id;

  acc_dispatcher i_acc_dispatcher (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .issue_valid_i    (issue_valid_i),
    .issue_trans_id_i (issue_trans_id_i),
    .issue_insn_i     (issue_insn_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_rs2_i      (issue_rs2_i),
    .issue_ready_o    (issue_ready_o),
    .commit_i         (commit_i),
    .commit_trans_id_i(commit_trans_id_i),
    .req_push_o       (req_push),
    .req_insn_o       (req_insn),
    .req_rs1_o        (req_rs1),
    .req_rs2_o        (req_rs2),
    .req_trans_id_o   (req_trans_id),
    .credit_ret_i     (credit_ret)
  );

  acc_req_buffer i_acc_req_buffer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (req_push),
    .insn_i      (req_insn),
    .rs1_i       (req_rs1),
    .rs2_i       (req_rs2),
    .trans_id_i  (req_trans_id),
    .pop_i       (buf_pop),
    .valid_o     (buf_valid),
    .insn_o      (buf_insn),
    .rs1_o       (buf_rs1),
    .rs2_o       (buf_rs2),
    .trans_id_o  (buf_trans_id),
    .credit_ret_o(credit_ret)
  );

  // Raw word goes onto the union port
  acc_alu i_acc_alu (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .buf_valid_i    (buf_valid),
    .insn_i         (buf_insn),
    .rs1_i          (buf_rs1),
    .rs2_i          (buf_rs2),
    .trans_id_i     (buf_trans_id),
    .buf_pop_o      (buf_pop),
    .resp_ready_i   (resp_ready_i),
    .resp_valid_o   (resp_valid_o),
    .resp_trans_id_o(resp_trans_id_o),
    .resp_result_o  (resp_result_o),
    .resp_error_o   (resp_error_o)
  );

endmodule

`default_nettype wire

/* bench/acc_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module acc_subsys_tb;

  import acc_cfg_pkg::*;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     flush;
  logic                     issue_valid;
  logic [TRANS_ID_BITS-1:0] issue_trans_id;
  logic [31:0]              issue_insn;
  logic [XLEN-1:0]          issue_rs1;
  logic [XLEN-1:0]          issue_rs2;
  logic                     issue_ready;
  logic                     commit;
  logic [TRANS_ID_BITS-1:0] commit_trans_id;
  logic                     resp_ready;
  logic                     resp_valid;
  logic [TRANS_ID_BITS-1:0] resp_trans_id;
  logic [XLEN-1:0]          resp_result;
  logic                     resp_error;

  // Stimulus lines, one entry per field
  logic [31:0] line_commit [$];
  logic [31:0] line_id     [$];
  logic [31:0] line_insn   [$];
  logic [31:0] line_rs1    [$];
  logic [31:0] line_rs2    [$];
  logic [31:0] line_res    [$];
  logic [31:0] line_err    [$];

  // Expected responses in commit order
  logic [TRANS_ID_BITS-1:0] exp_id_q  [$];
  logic [XLEN-1:0]          exp_res_q [$];
  logic                     exp_err_q [$];

  // Separate generators for commit gaps and back-pressure
  logic [31:0] gap_lfsr;
  logic [31:0] bp_lfsr;

  always #10 clk = ~clk;

  acc_subsys_top acc_subsys_top_i (
    .clk_i            (clk),
    .rst_i            (rst),
    .flush_i          (flush),
    .issue_valid_i    (issue_valid),
    .issue_trans_id_i (issue_trans_id),
    .issue_insn_i     (issue_insn),
    .issue_rs1_i      (issue_rs1),
    .issue_rs2_i      (issue_rs2),
    .issue_ready_o    (issue_ready),
    .commit_i         (commit),
    .commit_trans_id_i(commit_trans_id),
    .resp_ready_i     (resp_ready),
    .resp_valid_o     (resp_valid),
    .resp_trans_id_o  (resp_trans_id),
    .resp_result_o    (resp_result),
    .resp_error_o     (resp_error)
  );

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  // One LFSR step per bit taken, newest bit lands in bit 0
  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [7:0] bits);
    int k;
    bits = '0;
    for (k = 0; k < n; k++) begin
      bits  = {bits[6:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      stop_on_error($sformatf("Mismatch at %0d ns: %s expected %h, got %h",
                              $time, name, expected, actual));
    end
  endtask

  // Waits for room in the queue, then holds valid for exactly one cycle
  task automatic issue_line(input int idx);
    int waited;
    waited = 0;
    // Previous cycle had valid low, so ready seen here is current
    @(posedge clk);
    while (!issue_ready) begin
      @(posedge clk);
      waited++;
      if (waited > 200) begin
        stop_on_error("Timeout waiting for issue_ready_o");
      end
    end
    issue_valid    <= 1'b1;
    issue_trans_id <= line_id[idx][TRANS_ID_BITS-1:0];
    issue_insn     <= line_insn[idx];
    issue_rs1      <= line_rs1[idx];
    issue_rs2      <= line_rs2[idx];
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  // Random gap of 0 to 3 cycles, then a one-cycle commit pulse
  task automatic commit_line(input int idx);
    logic [7:0] bits;
    draw_bits(gap_lfsr, 2, bits);
    repeat (int'(bits[1:0])) @(posedge clk);
    commit          <= 1'b1;
    commit_trans_id <= line_id[idx][TRANS_ID_BITS-1:0];
    exp_id_q.push_back(line_id[idx][TRANS_ID_BITS-1:0]);
    exp_res_q.push_back(line_res[idx]);
    exp_err_q.push_back(line_err[idx][0]);
    @(posedge clk);
    commit <= 1'b0;
  endtask

  task automatic flush_queue();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  // Queue is read on the falling edge, away from the monitor's updates
  task automatic wait_drained();
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_id_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > 2000) begin
        stop_on_error("Timeout waiting for outstanding responses to drain");
      end
    end
  endtask

  // Response monitor, sampled at the handshake edge
  always @(posedge clk) begin
    if (!rst && resp_valid && resp_ready) begin
      if (exp_id_q.size() == 0) begin
        stop_on_error("A response arrived while no response was expected");
      end else begin
        check_field("resp_trans_id_o", 32'(exp_id_q[0]), 32'(resp_trans_id));
        check_field("resp_result_o", exp_res_q[0], resp_result);
        check_field("resp_error_o", 32'(exp_err_q[0]), 32'(resp_error));
        void'(exp_id_q.pop_front());
        void'(exp_res_q.pop_front());
        void'(exp_err_q.pop_front());
      end
    end
  end

  // Back-pressure with short drops and long stalls that use up the credits
  initial begin : backpressure
    logic [7:0] bits;
    int         stall;
    int         waited;
    bp_lfsr = 32'he368_f743;
    waited  = 0;
    while (rst !== 1'b0) begin
      @(posedge clk);
      waited++;
      if (waited > 100) begin
        stop_on_error("Timeout waiting for reset to be released");
      end
    end
    forever begin
      @(posedge clk);
      draw_bits(bp_lfsr, 4, bits);
      if (bits[3:0] == 4'b0000) begin
        draw_bits(bp_lfsr, 4, bits);
        stall = 24 + int'(bits[3:0]);
        resp_ready <= 1'b0;
        repeat (stall) @(posedge clk);
        resp_ready <= 1'b1;
      end else begin
        draw_bits(bp_lfsr, 2, bits);
        resp_ready <= (bits[1:0] != 2'b00);
      end
    end
  end

  initial begin : stimulus
    int          fd;
    int          n;
    int          idx;
    int          waited;
    int          idle;
    string       text;
    logic        in_group;
    logic [31:0] f_commit, f_id, f_insn, f_rs1, f_rs2, f_res, f_err;
    // All DUT inputs quiet, reset held
    rst             = 1'b1;
    flush           = 1'b0;
    issue_valid     = 1'b0;
    issue_trans_id  = '0;
    issue_insn      = '0;
    issue_rs1       = '0;
    issue_rs2       = '0;
    commit          = 1'b0;
    commit_trans_id = '0;
    resp_ready      = 1'b1;
    gap_lfsr        = 32'he368_f743;

    fd = $fopen("bench/acc_stimulus.txt", "r");
    if (fd == 0) begin
      stop_on_error("Could not open bench/acc_stimulus.txt");
    end
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      // Lines starting with # are comments
      if (n > 0 && text.len() > 0 && text.getc(0) != 8'h23) begin
        n = $sscanf(text, "%h %h %h %h %h %h %h",
                    f_commit, f_id, f_insn, f_rs1, f_rs2, f_res, f_err);
        if (n == 7) begin
          line_commit.push_back(f_commit);
          line_id.push_back(f_id);
          line_insn.push_back(f_insn);
          line_rs1.push_back(f_rs1);
          line_rs2.push_back(f_rs2);
          line_res.push_back(f_res);
          line_err.push_back(f_err);
        end else if (n > 0) begin
          stop_on_error($sformatf("Malformed stimulus line: %s", text));
        end
      end
    end
    $fclose(fd);
    if (line_insn.size() == 0) begin
      stop_on_error("The stimulus file holds no instructions");
    end

    repeat (8) @(posedge clk);
    rst <= 1'b0;

    in_group = 1'b0;
    for (idx = 0; idx < line_insn.size(); idx++) begin
      if (line_commit[idx][0]) begin
        // Speculative group ends here
        if (in_group) begin
          flush_queue();
          in_group = 1'b0;
        end
        issue_line(idx);
        commit_line(idx);
      end else begin
        // Drain first so the flush only hits speculative entries
        if (!in_group) begin
          wait_drained();
          in_group = 1'b1;
        end
        issue_line(idx);
      end
    end
    if (in_group) begin
      flush_queue();
    end

    // Done once nothing is outstanding and the port stays quiet
    idle   = 0;
    waited = 0;
    while (idle < 200) begin
      @(negedge clk);
      waited++;
      if (resp_valid || exp_id_q.size() != 0) begin
        idle = 0;
      end else begin
        idle++;
      end
      if (waited > 5000) begin
        stop_on_error("Timeout with responses still outstanding at the end of the run");
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/acc_stimulus.txt */
# commit trans_id insn rs1 rs2 exp_result exp_error, all hex
# commit 0 lines stay speculative and are flushed, so they never respond
1 0 0031008B 00000007 00000005 0000000C 0
1 1 0031008B FFFFFFFF 00000001 00000000 0
1 2 4031008B 00000005 00000007 FFFFFFFE 0
1 3 0031108B 00000010 00000001 0000000F 0
1 4 0031408B F0F0F0F0 0FF00FF0 FF00FF00 0
1 5 0031708B DEADBEEF 0000FFFF 0000BEEF 0
0 6 0031008B 11111111 22222222 33333333 0
0 7 005100AB 00000001 00000000 00000006 0
1 0 005100AB 00000064 00000000 00000069 0
1 1 FFF100AB 00000010 00000000 0000000F 0
1 2 800100AB 00001000 00000000 00000800 0
1 3 FFF140AB 12345678 00000000 EDCBA987 0
1 4 0F0170AB DEADBEEF 00000000 000000E0 0
1 5 800170AB 12345678 00000000 12345000 0
1 6 005110AB 00000009 00000000 00000000 1
1 7 00000033 00000001 00000002 00000000 1
1 0 0031208B 00000001 00000002 00000000 1
0 1 4031008B 00000009 00000001 00000008 0
0 2 0031708B FFFFFFFF FFFFFFFF FFFFFFFF 0
1 3 0031408B A5A5A5A5 5A5A5A5A FFFFFFFF 0
1 4 0031008B 7FFFFFFF 00000001 80000000 0
1 5 0031108B 00000000 00000001 FFFFFFFF 0

/* acc_subsys_top.f */
src/acc_cfg_pkg.sv
src/acc_isa_pkg.sv
src/acc_dispatcher.sv
src/acc_req_buffer.sv
src/acc_alu.sv
src/acc_subsys_top.sv
bench/acc_subsys_tb.sv

/* Makefile */
TB_TOP = acc_subsys_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TB_TOP) -f acc_subsys_top.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f acc_subsys_top.f -o acc_subsys_sim
	./obj_dir/acc_subsys_sim

clean:
	rm -rf obj_dir
